/* usb_prot_consts.svh */
`ifndef USB_PROT_CONSTS_SVH
`define USB_PROT_CONSTS_SVH

// Sync pattern that opens every frame
`define USB_SYNC_HI 8'h5E
`define USB_SYNC_LO 8'h4D

// CRC-8, MSB first, initial value zero
`define USB_CRC_POLY 8'h07

// Bytes per input and output bus word
`define USB_WORD_BYTES 4

// Address, length high, length low, header CRC
`define USB_HDR_BYTES 4

// Repacking buffer depth in bytes
`define USB_BUF_BYTES 8

`define USB_LEN_W 16

`endif

/* usb_prot_pkg.sv */
`include "usb_prot_consts.svh"

package usb_prot_pkg;

	// One input word as seen by a single stage
	typedef struct packed {
		logic                          valid;
		logic [`USB_WORD_BYTES*8-1:0]  data;
		logic [1:0]                    first;
		logic [2:0]                    cnt;
	} beat_t;

	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] len_hi;
		logic [7:0] len_lo;
		logic [7:0] crc;
	} hdr_fields_t;

	// Byte 0 is the address, byte 3 the header CRC
	typedef union packed {
		hdr_fields_t                       f;
		logic [0:`USB_HDR_BYTES-1][7:0]    b;
	} hdr_word_u;

	typedef enum logic [1:0] {
		HUNT,
		HEADER,
		PAYLOAD
	} frame_state_e;

	function automatic logic [7:0] crc8_step(input logic [7:0] crc, input logic [7:0] data);
		logic [7:0] c;
		c = crc ^ data;
		for (int i = 0; i < 8; i++)
		begin
			if (c[7])
				c = (c << 1) ^ `USB_CRC_POLY;
			else
				c = c << 1;
		end
		return c;
	endfunction

endpackage

/* frame_ctrl.sv */
`timescale 1ns/1ps
`include "usb_prot_consts.svh"

module frame_ctrl
	import usb_prot_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          op_i,
	input  logic [`USB_WORD_BYTES*8-1:0]  op_dat_i,
	input  logic [2:0]                    op_cnt_i,
	input  logic                          sync_hit_i,
	input  logic [1:0]                    sync_end_i,
	input  logic                          hdr_done_i,
	input  logic                          hdr_ok_i,
	input  logic [1:0]                    hdr_end_i,
	input  logic                          pay_done_i,
	output beat_t                         hunt_beat_o,
	output beat_t                         hdr_beat_o,
	output beat_t                         pay_beat_o
);

	frame_state_e state_q;
	frame_state_e state_n;
	logic [2:0]   sync_end;
	logic [2:0]   hdr_end;
	logic         hdr_live;
	logic         pay_live;
	logic [1:0]   hdr_first;
	logic [1:0]   pay_first;
	logic [2:0]   hdr_cnt;
	logic [2:0]   pay_cnt;

	// End lane zero after a hit means the whole word was consumed
	assign sync_end = {sync_end_i == 2'd0, sync_end_i};
	assign hdr_end  = {hdr_end_i == 2'd0, hdr_end_i};

	always_comb
	begin
		hdr_live  = 1'b0;
		hdr_first = 2'd0;
		hdr_cnt   = op_cnt_i;
		if (state_q == HEADER)
			hdr_live = op_i;
		else if (state_q == HUNT)
		begin
			hdr_live  = sync_hit_i;
			hdr_first = sync_end[1:0];
			hdr_cnt   = op_cnt_i - sync_end;
		end

		// Payload starts in the same word when the header closes early
		pay_live  = hdr_live & hdr_done_i & hdr_ok_i;
		pay_first = hdr_end[1:0];
		pay_cnt   = op_cnt_i - hdr_end;
		if (state_q == PAYLOAD)
		begin
			pay_live  = op_i;
			pay_first = 2'd0;
			pay_cnt   = op_cnt_i;
		end
	end

	always_comb
	begin
		hunt_beat_o.valid = op_i && (state_q == HUNT);
		hunt_beat_o.data  = op_dat_i;
		hunt_beat_o.first = 2'd0;
		hunt_beat_o.cnt   = op_cnt_i;

		hdr_beat_o.valid  = hdr_live && (hdr_cnt != 3'd0);
		hdr_beat_o.data   = op_dat_i;
		hdr_beat_o.first  = hdr_first;
		hdr_beat_o.cnt    = hdr_cnt;

		pay_beat_o.valid  = pay_live && (pay_cnt != 3'd0);
		pay_beat_o.data   = op_dat_i;
		pay_beat_o.first  = pay_first;
		pay_beat_o.cnt    = pay_cnt;
	end

	always_comb
	begin
		state_n = state_q;
		if (state_q == HUNT && sync_hit_i)
			state_n = HEADER;
		if (hdr_live && hdr_done_i)
			state_n = hdr_ok_i ? PAYLOAD : HUNT;
		if (pay_done_i)
			state_n = HUNT;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state_q <= HUNT;
		else
			state_q <= state_n;
	end

endmodule

/* sync_hunter.sv */
`timescale 1ns/1ps
`include "usb_prot_consts.svh"

module sync_hunter
	import usb_prot_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  beat_t      beat_i,
	output logic       sync_hit_o,
	output logic [1:0] sync_end_o
);

	logic [0:`USB_WORD_BYTES-1][7:0] lane_b;
	logic [2:0]                      end_lane;
	logic [2:0]                      hit_end;
	logic                            hit;
	logic                            tail_5e;
	logic                            held_5e;

	// Lane 0 is the most significant byte
	assign lane_b   = beat_i.data;
	assign end_lane = {1'b0, beat_i.first} + beat_i.cnt;

	always_comb
	begin
		hit     = 1'b0;
		hit_end = 3'd0;

		// Split sync, 5E held from the previous word
		if (held_5e && (beat_i.cnt != 3'd0) && (lane_b[beat_i.first] == `USB_SYNC_LO))
		begin
			hit     = 1'b1;
			hit_end = {1'b0, beat_i.first} + 3'd1;
		end

		for (int k = 0; k < `USB_WORD_BYTES - 1; k++)
		begin
			if (!hit && (3'(k) >= {1'b0, beat_i.first}) && (3'(k + 2) <= end_lane) &&
				(lane_b[k] == `USB_SYNC_HI) && (lane_b[k + 1] == `USB_SYNC_LO))
			begin
				hit     = 1'b1;
				hit_end = 3'(k + 2);
			end
		end
	end

	// Last owned byte may open a sync that ends in the next word
	assign tail_5e = (beat_i.cnt != 3'd0) &&
		(lane_b[2'(end_lane - 3'd1)] == `USB_SYNC_HI);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			held_5e <= 1'b0;
		else if (beat_i.valid)
			held_5e <= tail_5e & ~hit;
	end

	assign sync_hit_o = beat_i.valid & hit;
	assign sync_end_o = hit_end[1:0];

endmodule

/* hdr_capture.sv */
`timescale 1ns/1ps
`include "usb_prot_consts.svh"

module hdr_capture
	import usb_prot_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  beat_t                 beat_i,
	output logic                  hdr_done_o,
	output logic                  hdr_ok_o,
	output logic [1:0]            hdr_end_o,
	output logic [`USB_LEN_W-1:0] len_o,
	output logic [7:0]            addr_o
);

	logic [0:`USB_WORD_BYTES-1][7:0] lane_b;
	hdr_word_u                       hdr_q;
	hdr_word_u                       hdr_n;
	logic [1:0]                      fill_q;
	logic [1:0]                      fill_n;
	logic [2:0]                      pos;
	logic [2:0]                      lane;
	logic                            done;
	logic [2:0]                      done_end;
	logic [7:0]                      crc_sync;
	logic [7:0]                      crc_calc;
	logic [`USB_LEN_W-1:0]           len_q;
	logic [7:0]                      addr_q;

	assign lane_b = beat_i.data;

	always_comb
	begin
		hdr_n    = hdr_q;
		pos      = {1'b0, fill_q};
		lane     = {1'b0, beat_i.first};
		done     = 1'b0;
		done_end = 3'd0;
		for (int i = 0; i < `USB_WORD_BYTES; i++)
		begin
			if (beat_i.valid && (3'(i) < beat_i.cnt) && !done)
			begin
				lane = {1'b0, beat_i.first} + 3'(i);
				hdr_n.b[pos[1:0]] = lane_b[lane[1:0]];
				if (pos == 3'(`USB_HDR_BYTES - 1))
				begin
					done     = 1'b1;
					done_end = lane + 3'd1;
				end
				pos = pos + 3'd1;
			end
		end
		fill_n = done ? 2'd0 : pos[1:0];
	end

	// Sync bytes are part of the header CRC
	assign crc_sync = crc8_step(crc8_step(8'h00, `USB_SYNC_HI), `USB_SYNC_LO);
	assign crc_calc = crc8_step(crc8_step(crc8_step(crc_sync, hdr_n.f.addr),
		hdr_n.f.len_hi), hdr_n.f.len_lo);

	assign hdr_done_o = done;
	assign hdr_ok_o   = done && (crc_calc == hdr_n.f.crc);
	assign hdr_end_o  = done_end[1:0];

	// New length is needed by the packer in the header word itself
	assign len_o  = hdr_ok_o ? {hdr_n.f.len_hi, hdr_n.f.len_lo} : len_q;
	assign addr_o = hdr_ok_o ? hdr_n.f.addr : addr_q;

	always_ff @(posedge clk)
	begin
		if (beat_i.valid)
			hdr_q <= hdr_n;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fill_q <= 2'd0;
			len_q  <= '0;
			addr_q <= 8'h00;
		end
		else
		begin
			if (beat_i.valid)
				fill_q <= fill_n;
			if (hdr_ok_o)
			begin
				len_q  <= {hdr_n.f.len_hi, hdr_n.f.len_lo};
				addr_q <= hdr_n.f.addr;
			end
		end
	end

endmodule

/* payload_packer.sv */
`timescale 1ns/1ps
`include "usb_prot_consts.svh"

module payload_packer
	import usb_prot_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  beat_t                         beat_i,
	input  logic [`USB_LEN_W-1:0]         len_i,
	input  logic                          hdr_ok_i,
	output logic                          pay_done_o,
	output logic                          dat_en_o,
	output logic [`USB_WORD_BYTES*8-1:0]  dat_o,
	output logic [2:0]                    dat_be_o,
	output logic                          frame_done_o,
	output logic                          crc_err_o
);

	logic [0:`USB_WORD_BYTES-1][7:0] lane_b;
	logic [0:`USB_BUF_BYTES-1][7:0]  buf_q;
	logic [0:`USB_BUF_BYTES-1][7:0]  buf_n;
	logic [3:0]                      fill_q;
	logic [3:0]                      fill_n;
	logic [`USB_LEN_W-1:0]           rem_q;
	logic [`USB_LEN_W-1:0]           rem_n;
	logic [7:0]                      crc_q;
	logic [7:0]                      crc_n;
	logic [7:0]                      crc_rx;
	logic [2:0]                      lane;
	logic                            got_crc;
	logic                            closing_q;
	logic                            bad_q;
	logic                            close;
	logic                            bad;
	logic                            hold;
	logic                            emit;
	logic                            last;
	logic [2:0]                      be;
	logic                            dat_en_q;
	logic [`USB_WORD_BYTES*8-1:0]    dat_q;
	logic [2:0]                      be_q;
	logic                            frame_done_q;
	logic                            crc_err_q;

	assign lane_b = beat_i.data;

	always_comb
	begin
		buf_n   = buf_q;
		fill_n  = fill_q;
		rem_n   = hdr_ok_i ? len_i : rem_q;
		crc_n   = hdr_ok_i ? 8'h00 : crc_q;
		crc_rx  = 8'h00;
		lane    = {1'b0, beat_i.first};
		got_crc = 1'b0;
		for (int i = 0; i < `USB_WORD_BYTES; i++)
		begin
			if (beat_i.valid && (3'(i) < beat_i.cnt) && !got_crc)
			begin
				lane = {1'b0, beat_i.first} + 3'(i);
				if (rem_n != '0)
				begin
					buf_n[fill_n[2:0]] = lane_b[lane[1:0]];
					crc_n  = crc8_step(crc_n, lane_b[lane[1:0]]);
					rem_n  = rem_n - 1'b1;
					fill_n = fill_n + 4'd1;
				end
				else
				begin
					// First byte past the payload is the frame CRC
					got_crc = 1'b1;
					crc_rx  = lane_b[lane[1:0]];
				end
			end
		end

		close = closing_q | got_crc;
		bad   = closing_q ? bad_q : (crc_rx != crc_n);

		// Keep a full last word back until the CRC byte closes the frame
		hold  = !close && (rem_n == '0) && (fill_n == 4'd4);
		emit  = ((fill_n >= 4'd4) && !hold) || (close && (fill_n != 4'd0));
		last  = close && (fill_n <= 4'd4);
		be    = (fill_n >= 4'd4) ? 3'd4 : fill_n[2:0];
	end

	always_ff @(posedge clk)
	begin
		buf_q <= emit ? (buf_n << (`USB_WORD_BYTES * 8)) : buf_n;
		dat_q <= buf_n[0:`USB_WORD_BYTES-1];
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fill_q       <= 4'd0;
			rem_q        <= '0;
			crc_q        <= 8'h00;
			closing_q    <= 1'b0;
			bad_q        <= 1'b0;
			dat_en_q     <= 1'b0;
			be_q         <= 3'd0;
			frame_done_q <= 1'b0;
			crc_err_q    <= 1'b0;
		end
		else
		begin
			fill_q       <= emit ? (fill_n - {1'b0, be}) : fill_n;
			rem_q        <= rem_n;
			crc_q        <= crc_n;
			closing_q    <= close & ~last;
			bad_q        <= bad;
			dat_en_q     <= emit;
			be_q         <= be;
			frame_done_q <= last;
			crc_err_q    <= last & bad;
		end
	end

	assign pay_done_o   = got_crc;
	assign dat_en_o     = dat_en_q;
	assign dat_o        = dat_q;
	assign dat_be_o     = be_q;
	assign frame_done_o = frame_done_q;
	assign crc_err_o    = crc_err_q;

endmodule

/* usb_prot_decoder.sv */
`timescale 1ns/1ps
`include "usb_prot_consts.svh"

module usb_prot_decoder
	import usb_prot_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          op_i,
	input  logic [`USB_WORD_BYTES*8-1:0]  op_dat_i,
	input  logic [2:0]                    op_cnt_i,
	output logic                          dat_en_o,
	output logic [`USB_WORD_BYTES*8-1:0]  dat_o,
	output logic [2:0]                    dat_be_o,
	output logic [`USB_LEN_W-1:0]         dat_len_o,
	output logic [7:0]                    dat_addr_o,
	output logic                          frame_done_o,
	output logic                          crc_err_o
);

	beat_t      hunt_beat;
	beat_t      hdr_beat;
	beat_t      pay_beat;
	logic       sync_hit;
	logic [1:0] sync_end;
	logic       hdr_done;
	logic       hdr_ok;
	logic [1:0] hdr_end;
	logic       pay_done;

	frame_ctrl frame_ctrl_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.op_i        (op_i),
		.op_dat_i    (op_dat_i),
		.op_cnt_i    (op_cnt_i),
		.sync_hit_i  (sync_hit),
		.sync_end_i  (sync_end),
		.hdr_done_i  (hdr_done),
		.hdr_ok_i    (hdr_ok),
		.hdr_end_i   (hdr_end),
		.pay_done_i  (pay_done),
		.hunt_beat_o (hunt_beat),
		.hdr_beat_o  (hdr_beat),
		.pay_beat_o  (pay_beat)
	);

	sync_hunter sync_hunter_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.beat_i     (hunt_beat),
		.sync_hit_o (sync_hit),
		.sync_end_o (sync_end)
	);

	hdr_capture hdr_capture_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.beat_i     (hdr_beat),
		.hdr_done_o (hdr_done),
		.hdr_ok_o   (hdr_ok),
		.hdr_end_o  (hdr_end),
		.len_o      (dat_len_o),
		.addr_o     (dat_addr_o)
	);

	payload_packer payload_packer_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.beat_i       (pay_beat),
		.len_i        (dat_len_o),
		.hdr_ok_i     (hdr_ok),
		.pay_done_o   (pay_done),
		.dat_en_o     (dat_en_o),
		.dat_o        (dat_o),
		.dat_be_o     (dat_be_o),
		.frame_done_o (frame_done_o),
		.crc_err_o    (crc_err_o)
	);

endmodule

/* tb_usb_prot_decoder.sv */
`timescale 1ns/1ps

module tb_usb_prot_decoder;

	localparam logic [1:0] DROP   = 2'd0;
	localparam logic [1:0] GOOD   = 2'd1;
	localparam logic [1:0] CRCERR = 2'd2;
	localparam int NROWS = 18;

	typedef struct packed {
		logic [7:0]  garb;
		logic [7:0]  addr;
		logic [15:0] len;
		logic [7:0]  seed;
		logic        hdr_bad;
		logic        crc_bad;
		logic [1:0]  outcome;
	} frame_row_t;

	logic        clk;
	logic        rst_n;
	logic        op_i;
	logic [31:0] op_dat_i;
	logic [2:0]  op_cnt_i;
	logic        dat_en_o;
	logic [31:0] dat_o;
	logic [2:0]  dat_be_o;
	logic [15:0] dat_len_o;
	logic [7:0]  dat_addr_o;
	logic        frame_done_o;
	logic        crc_err_o;

	frame_row_t  rows [NROWS];
	logic [31:0] lfsr;
	logic [31:0] word_dat [$];
	logic [2:0]  word_cnt [$];
	logic [7:0]  exp_bytes [$];
	logic [7:0]  exp_addr [$];
	int          exp_len [$];
	logic        exp_err [$];
	int          checks;
	int          errors;
	int          fidx;
	int          bidx;
	int          rem;
	logic        first_evt;

	usb_prot_decoder usb_prot_decoder_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.op_i         (op_i),
		.op_dat_i     (op_dat_i),
		.op_cnt_i     (op_cnt_i),
		.dat_en_o     (dat_en_o),
		.dat_o        (dat_o),
		.dat_be_o     (dat_be_o),
		.dat_len_o    (dat_len_o),
		.dat_addr_o   (dat_addr_o),
		.frame_done_o (frame_done_o),
		.crc_err_o    (crc_err_o)
	);

	always
		#50 clk = ~clk;

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Bit serial CRC-8, poly 07, MSB first
	function automatic logic [7:0] crc_next(input logic [7:0] crc, input logic [7:0] d);
		logic [7:0] r;
		r = crc;
		for (int i = 7; i >= 0; i--)
		begin
			if (r[7] ^ d[i])
				r = {r[6:0], 1'b0} ^ 8'h07;
			else
				r = {r[6:0], 1'b0};
		end
		return r;
	endfunction

	task automatic add_frame(input frame_row_t row);
		logic [7:0]  fb [$];
		logic [7:0]  b;
		logic [7:0]  crc;
		logic [31:0] w;
		int          pos;
		int          n;
		int          cut_at;
		for (int g = 0; g < row.garb; g++)
		begin
			b = 8'(rand_bits(8));
			if (b == 8'h5E || b == 8'h4D)
				b = 8'h00;
			fb.push_back(b);
		end
		fb.push_back(8'h5E);
		fb.push_back(8'h4D);
		crc = crc_next(crc_next(8'h00, 8'h5E), 8'h4D);
		crc = crc_next(crc_next(crc_next(crc, row.addr), row.len[15:8]), row.len[7:0]);
		fb.push_back(row.addr);
		fb.push_back(row.len[15:8]);
		fb.push_back(row.len[7:0]);
		fb.push_back(row.hdr_bad ? ~crc : crc);
		crc = 8'h00;
		for (int i = 0; i < row.len; i++)
		begin
			// No 5E so a dropped frame cannot fake a sync
			b = 8'(rand_bits(8)) ^ row.seed;
			if (b == 8'h5E)
				b = 8'h5F;
			crc = crc_next(crc, b);
			fb.push_back(b);
			if (row.outcome != DROP)
				exp_bytes.push_back(b);
		end
		fb.push_back(row.crc_bad ? (crc ^ 8'h01) : crc);
		if (row.outcome != DROP)
		begin
			exp_addr.push_back(row.addr);
			exp_len.push_back(int'(row.len));
			exp_err.push_back(row.outcome == CRCERR);
		end
		// Odd garbage count forces 5E into the last lane of a word
		cut_at = row.garb[0] ? int'(row.garb) + 1 : 0;
		pos = 0;
		while (pos < fb.size())
		begin
			n = int'(rand_bits(2)) + 1;
			if (n > fb.size() - pos)
				n = fb.size() - pos;
			if (cut_at > pos && pos + n > cut_at)
				n = cut_at - pos;
			w = {4{8'h5E}};
			for (int k = 0; k < n; k++)
				w[31 - 8 * k -: 8] = fb[pos + k];
			word_dat.push_back(w);
			word_cnt.push_back(3'(n));
			pos += n;
		end
	endtask

	always @(negedge clk)
	begin : monitor
		int exp_be;
		if (rst_n && (dat_en_o || frame_done_o))
		begin
			if (fidx >= exp_len.size())
			begin
				errors++;
				$display("Output appeared with no frame left to expect at %0t", $time);
			end
			else
			begin
				// Length and address checked before a following header can replace them
				if (first_evt)
				begin
					check_val("dat_len_o", dat_len_o, exp_len[fidx]);
					check_val("dat_addr_o", dat_addr_o, exp_addr[fidx]);
					first_evt = 1'b0;
				end
				if (dat_en_o)
				begin
					exp_be = (rem > 4) ? 4 : rem;
					check_val("dat_be_o", dat_be_o, exp_be);
					for (int k = 0; k < exp_be; k++)
					begin
						check_val("dat_o", dat_o[31 - 8 * k -: 8], exp_bytes[bidx]);
						bidx++;
					end
					check_val("frame_done_o", frame_done_o, rem <= 4);
					rem -= exp_be;
				end
				if (frame_done_o)
				begin
					check_val("crc_err_o", crc_err_o, exp_err[fidx]);
					if (rem != 0)
					begin
						errors++;
						$display("Frame %0d ended with %0d payload bytes missing", fidx, rem);
						bidx += rem;
					end
					fidx++;
					first_evt = 1'b1;
					rem = (fidx < exp_len.size()) ? exp_len[fidx] : 0;
				end
			end
		end
		else if (rst_n && crc_err_o)
		begin
			errors++;
			$display("crc_err_o pulsed without frame_done_o at %0t", $time);
		end
	end

	initial
	begin
		int t;
		clk = 1'b0;
		rst_n = 1'b0;
		op_i = 1'b0;
		op_dat_i = 32'h0;
		op_cnt_i = 3'd0;
		lfsr = 32'h767d;
		checks = 0;
		errors = 0;
		fidx = 0;
		bidx = 0;
		first_evt = 1'b1;

		// garb, addr, len, seed, hdr_bad, crc_bad, outcome
		rows = '{
			'{8'd12, 8'h11, 16'd1,  8'h00, 1'b0, 1'b0, GOOD},
			'{8'd3,  8'h22, 16'd2,  8'h3C, 1'b0, 1'b0, GOOD},
			'{8'd0,  8'h33, 16'd3,  8'hA5, 1'b0, 1'b0, GOOD},
			'{8'd5,  8'h44, 16'd4,  8'h0F, 1'b0, 1'b0, GOOD},
			'{8'd1,  8'h55, 16'd5,  8'h81, 1'b0, 1'b0, GOOD},
			'{8'd0,  8'h66, 16'd6,  8'h17, 1'b0, 1'b0, GOOD},
			'{8'd7,  8'h77, 16'd7,  8'hE2, 1'b0, 1'b0, GOOD},
			'{8'd2,  8'h88, 16'd8,  8'h5A, 1'b0, 1'b0, GOOD},
			'{8'd9,  8'h99, 16'd9,  8'hC3, 1'b0, 1'b0, GOOD},
			'{8'd0,  8'hA0, 16'd0,  8'h00, 1'b0, 1'b0, GOOD},
			'{8'd4,  8'hB1, 16'd6,  8'h29, 1'b1, 1'b0, DROP},
			'{8'd0,  8'hB2, 16'd5,  8'h71, 1'b0, 1'b0, GOOD},
			'{8'd1,  8'hC3, 16'd7,  8'h9E, 1'b0, 1'b1, CRCERR},
			'{8'd6,  8'hD4, 16'd0,  8'h00, 1'b0, 1'b1, CRCERR},
			'{8'd0,  8'hE5, 16'd37, 8'h44, 1'b0, 1'b0, GOOD},
			'{8'd3,  8'hF6, 16'd12, 8'h18, 1'b1, 1'b0, DROP},
			'{8'd0,  8'h07, 16'd9,  8'hB7, 1'b0, 1'b1, CRCERR},
			'{8'd2,  8'h18, 16'd1,  8'h6D, 1'b0, 1'b0, GOOD}
		};
		for (int r = 0; r < NROWS; r++)
			add_frame(rows[r]);
		rem = exp_len[0];

		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_val("dat_en_o", dat_en_o, 0);
		check_val("frame_done_o", frame_done_o, 0);
		check_val("crc_err_o", crc_err_o, 0);

		for (int i = 0; i < word_dat.size(); i++)
		begin
			if (rand_bits(2) == 0)
			begin
				@(posedge clk);
				#1;
				op_i = 1'b0;
			end
			@(posedge clk);
			#1;
			op_i = 1'b1;
			op_dat_i = word_dat[i];
			op_cnt_i = word_cnt[i];
		end
		@(posedge clk);
		#1;
		op_i = 1'b0;

		for (t = 0; t < 500 && fidx < exp_len.size(); t++)
			@(posedge clk);
		if (fidx < exp_len.size())
		begin
			errors++;
			$display("Timed out waiting for frame_done_o after %0d of %0d frames",
				fidx, exp_len.size());
		end
		// Trailing idle cycles catch stray output
		repeat (8) @(posedge clk);

		$display("Checks: %0d  Errors: %0d  Frames: %0d of %0d", checks, errors, fidx,
			exp_len.size());
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* usb_prot_decoder.f */
+incdir+.
usb_prot_pkg.sv
frame_ctrl.sv
sync_hunter.sv
hdr_capture.sv
payload_packer.sv
usb_prot_decoder.sv
tb_usb_prot_decoder.sv

/* Makefile */
TB = tb_usb_prot_decoder

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module usb_prot_decoder -f usb_prot_decoder.f

sim:
	verilator --binary -Wno-fatal --top-module $(TB) -f usb_prot_decoder.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TB))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
